//--- include/tinker_config.svh
// Core configuration macros: reset PC, data and instruction widths, register count, PC step
`ifndef TINKER_CONFIG_SVH
`define TINKER_CONFIG_SVH

// ------------------------------
// Program counter
// ------------------------------
`define TINKER_RESET_PC   64'h0000_0000_0000_2000  // First fetch address
`define TINKER_PC_STEP    4                        // One instruction word

// ------------------------------
// Datapath widths
// ------------------------------
`define TINKER_WORD_BITS  64   // Register and memory data word
`define TINKER_INSTR_BITS 32   // Instruction word
`define TINKER_IMM_BITS   12   // Immediate field, sign-extended
`define TINKER_NUM_REGS   32   // General purpose registers

`endif

//--- source/tinker_pkg.sv
// Shared core types: words, opcodes, classes, states, decoded fields, strobes, memory request
`include "tinker_config.svh"

package tinker_pkg;

    typedef logic [`TINKER_WORD_BITS-1:0]          word_t;     // Data word
    typedef logic [`TINKER_INSTR_BITS-1:0]         instr_t;    // Instruction word
    typedef logic [$clog2(`TINKER_NUM_REGS)-1:0]   reg_idx_t;  // Register number

    // ------------------------------
    // Opcodes kept in this core
    // ------------------------------
    typedef enum logic [4:0] {
        op_and     = 5'b00000,
        op_or      = 5'b00001,
        op_xor     = 5'b00010,
        op_not     = 5'b00011,
        op_shftr   = 5'b00100,  // Logical right
        op_shftri  = 5'b00101,  // Arithmetic right by literal
        op_shftl   = 5'b00110,
        op_shftli  = 5'b00111,
        op_load    = 5'b10000,
        op_mov_rr  = 5'b10001,
        op_mov_lit = 5'b10010,
        op_store   = 5'b10011,
        op_add     = 5'b11000,
        op_addi    = 5'b11001,
        op_sub     = 5'b11010,
        op_subi    = 5'b11011,
        op_mul     = 5'b11100,
        op_div     = 5'b11101,
        op_halt    = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        cls_alu,    // Includes both moves
        cls_load,
        cls_store,
        cls_nop,    // Branches, calls and undefined codes
        cls_halt
    } op_class_t;

    // Decoded instruction fields
    typedef struct packed {
        opcode_t   opcode;
        op_class_t op_class;
        reg_idx_t  rd;
        reg_idx_t  rs;
        reg_idx_t  rt;
        word_t     imm;          // Sign-extended literal
        logic      use_literal;  // Operand 2 is imm
    } decoded_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } core_state_t;

    // Control strobes, one cycle each
    typedef struct packed {
        logic ir_write;
        logic pc_advance;
        logic alu_capture;
        logic mdr_capture;
        logic reg_write;
        logic mem_to_reg;
        logic mem_read;
        logic mem_write;
    } ctrl_t;

    // Request to the external byte memory
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } mem_req_t;

endpackage

//--- source/core_control.sv
// Core FSM: state register, next-state logic, control strobes and halt flag
`timescale 1ns/1ps

module core_control (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::decoded_t dec,
    output tinker_pkg::ctrl_t    ctrl,
    output logic                 hlt
);
    import tinker_pkg::*;

    core_state_t state;       // Current phase
    core_state_t state_next;

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // One cycle per state
    always_comb begin
        state_next = state;
        case (state)
            st_fetch:     state_next = st_decode;
            st_decode: begin
                if (dec.op_class == cls_halt) begin
                    state_next = st_halted;  // Skips execute
                end else begin
                    state_next = st_execute;
                end
            end
            st_execute: begin
                if (dec.op_class == cls_load || dec.op_class == cls_store) begin
                    state_next = st_memory;
                end else begin
                    state_next = st_writeback;  // ALU, moves, no-ops
                end
            end
            st_memory:    state_next = st_writeback;
            st_writeback: state_next = st_fetch;
            st_halted:    state_next = st_halted;  // Until reset
            default:      state_next = st_fetch;
        endcase
    end

    // ------------------------------
    // Strobes
    // ------------------------------
    always_comb begin
        ctrl = '0;  // All idle by default
        case (state)
            st_fetch: begin
                ctrl.ir_write = 1'b1;  // Latch instruction
                ctrl.mem_read = 1'b1;
            end
            st_execute: begin
                ctrl.alu_capture = (dec.op_class == cls_alu);
            end
            st_memory: begin
                ctrl.mem_read    = (dec.op_class == cls_load);
                ctrl.mdr_capture = (dec.op_class == cls_load);
                ctrl.mem_write   = (dec.op_class == cls_store);
            end
            st_writeback: begin
                ctrl.reg_write  = (dec.op_class == cls_alu) || (dec.op_class == cls_load);
                ctrl.mem_to_reg = (dec.op_class == cls_load);  // Load data path
                ctrl.pc_advance = 1'b1;
            end
            default: begin
                ctrl = '0;  // Decode and halted drive nothing
            end
        endcase
    end

    assign hlt = (state == st_halted);

    // Single memory access per cycle
    a_no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.mem_read && ctrl.mem_write));

    // Core stays quiet once stopped
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        hlt |-> (ctrl == '0));

endmodule

//--- source/instr_fetch.sv
// Program counter, instruction register and instruction field decode
`timescale 1ns/1ps
`include "tinker_config.svh"

module instr_fetch (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::ctrl_t    ctrl,
    input  tinker_pkg::instr_t   instr_word,  // From memory in fetch
    output tinker_pkg::word_t    pc,
    output tinker_pkg::decoded_t dec
);
    import tinker_pkg::*;

    instr_t ir;  // Instruction register

    // ------------------------------
    // PC and IR
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `TINKER_RESET_PC;
        end else if (ctrl.pc_advance) begin
            pc <= pc + word_t'(`TINKER_PC_STEP);  // Sequential only
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir <= '0;
        end else if (ctrl.ir_write) begin
            ir <= instr_word;
        end
    end

    // Field slicing
    always_comb begin
        dec.opcode = opcode_t'(ir[31:27]);
        dec.rd     = ir[26:22];
        dec.rs     = ir[21:17];
        dec.rt     = ir[16:12];
        dec.imm    = {{(`TINKER_WORD_BITS - `TINKER_IMM_BITS){ir[`TINKER_IMM_BITS-1]}},
                      ir[`TINKER_IMM_BITS-1:0]};  // Sign extend

        // Class and literal select
        dec.use_literal = 1'b0;
        case (ir[31:27])
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftl, op_mov_rr,
            op_add, op_sub, op_mul, op_div: begin
                dec.op_class = cls_alu;
            end
            op_shftri, op_shftli, op_mov_lit, op_addi, op_subi: begin
                dec.op_class    = cls_alu;
                dec.use_literal = 1'b1;
            end
            op_load: begin
                dec.op_class    = cls_load;
                dec.use_literal = 1'b1;  // Offset from rs
            end
            op_store: begin
                dec.op_class    = cls_store;
                dec.use_literal = 1'b1;  // Offset from rd
            end
            op_halt:  dec.op_class = cls_halt;
            default:  dec.op_class = cls_nop;  // Branches and unknown codes
        endcase
    end

    // Word alignment of the fetch address
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

//--- source/reg_file.sv
// General purpose register file: three combinational reads, one write, register 0 fixed at zero
`timescale 1ns/1ps
`include "tinker_config.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::ctrl_t    ctrl,
    input  tinker_pkg::decoded_t dec,
    input  tinker_pkg::word_t    wb_data,  // From writeback select
    output tinker_pkg::word_t    rs_val,
    output tinker_pkg::word_t    rt_val,
    output tinker_pkg::word_t    rd_val    // Store base address
);
    import tinker_pkg::*;

    word_t regs [`TINKER_NUM_REGS];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && (dec.rd != '0)) begin
            regs[dec.rd] <= wb_data;  // r0 never written
        end
    end

    // Read ports
    assign rs_val = regs[dec.rs];
    assign rt_val = regs[dec.rt];
    assign rd_val = regs[dec.rd];

    // r0 holds zero through any writeback
    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        regs[0] == '0);

endmodule

//--- source/alu.sv
// Operand 2 select and the sixteen arithmetic, logic, shift and move operations
`timescale 1ns/1ps
`include "tinker_config.svh"

module alu (
    input  tinker_pkg::decoded_t dec,
    input  tinker_pkg::word_t    rs_val,
    input  tinker_pkg::word_t    rt_val,
    output tinker_pkg::word_t    alu_result
);
    import tinker_pkg::*;

    localparam int SHAMT_BITS = $clog2(`TINKER_WORD_BITS);

    word_t                 operand2;    // Register or literal
    logic [SHAMT_BITS-1:0] shamt;
    logic                  shift_over;  // Amount of a full word or more
    word_t                 sra_value;

    assign operand2   = dec.use_literal ? dec.imm : rt_val;
    assign shamt      = operand2[SHAMT_BITS-1:0];
    assign shift_over = |operand2[`TINKER_WORD_BITS-1:SHAMT_BITS];
    assign sra_value  = $signed(rs_val) >>> shamt;  // Sign fill

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        alu_result = '0;  // Non-alu classes
        if (dec.op_class == cls_alu) begin
            case (dec.opcode)
                op_and:     alu_result = rs_val & operand2;
                op_or:      alu_result = rs_val | operand2;
                op_xor:     alu_result = rs_val ^ operand2;
                op_not:     alu_result = ~rs_val;
                op_shftr:   alu_result = shift_over ? '0 : (rs_val >> shamt);
                op_shftri: begin
                    alu_result = shift_over ? {`TINKER_WORD_BITS{rs_val[`TINKER_WORD_BITS-1]}}
                                            : sra_value;
                end
                op_shftl,
                op_shftli:  alu_result = shift_over ? '0 : (rs_val << shamt);
                op_add,
                op_addi:    alu_result = rs_val + operand2;
                op_sub,
                op_subi:    alu_result = rs_val - operand2;
                op_mul:     alu_result = rs_val * operand2;  // Low word kept
                op_div:     alu_result = (operand2 == '0) ? '0 : (rs_val / operand2);
                op_mov_rr:  alu_result = rs_val;
                op_mov_lit: alu_result = dec.imm;
                default:    alu_result = '0;
            endcase
        end
    end

endmodule

//--- source/mem_access.sv
// Data address and store data, ALU result and memory data registers, writeback select
`timescale 1ns/1ps

module mem_access (
    input  logic                 clk,
    input  logic                 reset,
    input  tinker_pkg::ctrl_t    ctrl,
    input  tinker_pkg::decoded_t dec,
    input  tinker_pkg::word_t    rs_val,
    input  tinker_pkg::word_t    rd_val,
    input  tinker_pkg::word_t    alu_result,
    input  tinker_pkg::word_t    mem_rdata,   // Load data, same cycle
    output tinker_pkg::word_t    data_addr,
    output tinker_pkg::word_t    store_data,
    output tinker_pkg::word_t    wb_data
);
    import tinker_pkg::*;

    word_t base_addr;
    word_t alu_reg;  // Result held for writeback
    word_t mdr;      // Memory data register

    // ------------------------------
    // Address generation
    // ------------------------------
    assign base_addr  = (dec.op_class == cls_store) ? rd_val : rs_val;  // Store uses rd
    assign data_addr  = base_addr + dec.imm;
    assign store_data = rs_val;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_reg <= '0;
        end else if (ctrl.alu_capture) begin
            alu_reg <= alu_result;  // End of execute
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mdr <= '0;
        end else if (ctrl.mdr_capture) begin
            mdr <= mem_rdata;  // End of memory cycle
        end
    end

    // Writeback source
    assign wb_data = ctrl.mem_to_reg ? mdr : alu_reg;

endmodule

//--- source/tinker_core.sv
// Core top level: control and datapath instances, fetch/data address select for the memory request
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_core (
    input  logic                 clk,
    input  logic                 reset,
    output tinker_pkg::mem_req_t mem_req,    // To external memory
    input  tinker_pkg::word_t    mem_rdata,  // Same-cycle read data
    output logic                 hlt
);
    import tinker_pkg::*;

    ctrl_t    ctrl;        // Strobes from the FSM
    decoded_t dec;         // Fields of the current instruction
    instr_t   instr_word;  // Fetched word
    word_t    pc;
    word_t    rs_val;
    word_t    rt_val;
    word_t    rd_val;
    word_t    alu_result;
    word_t    wb_data;
    word_t    data_addr;
    word_t    store_data;

    assign instr_word = mem_rdata[`TINKER_INSTR_BITS-1:0];  // Low half holds the instruction

    // ------------------------------
    // Memory request
    // ------------------------------
    always_comb begin
        mem_req.addr  = ctrl.ir_write ? pc : data_addr;  // PC during fetch only
        mem_req.wdata = store_data;
        mem_req.read  = ctrl.mem_read;
        mem_req.write = ctrl.mem_write;
    end

    core_control u_control (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .ctrl  (ctrl),
        .hlt   (hlt)
    );

    instr_fetch u_fetch (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .instr_word (instr_word),
        .pc         (pc),
        .dec        (dec)
    );

    reg_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .dec     (dec),
        .wb_data (wb_data),
        .rs_val  (rs_val),
        .rt_val  (rt_val),
        .rd_val  (rd_val)
    );

    alu u_alu (
        .dec        (dec),
        .rs_val     (rs_val),
        .rt_val     (rt_val),
        .alu_result (alu_result)
    );

    mem_access u_mem (
        .clk        (clk),
        .reset      (reset),
        .ctrl       (ctrl),
        .dec        (dec),
        .rs_val     (rs_val),
        .rd_val     (rd_val),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .data_addr  (data_addr),
        .store_data (store_data),
        .wb_data    (wb_data)
    );

endmodule

//--- tests/tinker_tb.sv
// Core testbench: clock, reset, byte memory, random programs, instruction model and checks
`timescale 1ns/1ps
`include "tinker_config.svh"

module tinker_tb;
    import tinker_pkg::*;

    localparam int MEM_BYTES = 65536;
    localparam int DATA_BASE = 'h400;  // 512 bytes of random data
    localparam int DUMP_BASE = 'h600;  // 32-word register dump
    localparam int RUN_LIMIT = 4000;   // Cycles or steps per program

    logic     clk;
    logic     reset;
    mem_req_t mem_req;
    word_t    mem_rdata;
    logic     hlt;

    logic [7:0] mem [MEM_BYTES];      // Memory seen by the DUT
    logic [7:0] ref_mem [MEM_BYTES];  // Model copy
    word_t      ref_regs [32];
    instr_t     prog [$];
    integer     seed = 46;
    int         test_errors;
    int         tests_run;
    int         tests_failed;
    logic [4:0] alu_ops [18] = '{op_and, op_or, op_xor, op_not, op_shftr, op_shftri, op_shftl,
                                 op_shftli, op_add, op_addi, op_sub, op_subi, op_mul, op_div,
                                 op_mov_rr, op_mov_lit, op_and, op_add};
    logic [4:0] nop_ops [13] = '{5'h08, 5'h09, 5'h0A, 5'h0B, 5'h0C, 5'h0D, 5'h0E, 5'h0F,
                                 5'h14, 5'h15, 5'h16, 5'h17, 5'h1E};  // Dropped codes

    tinker_core DUT (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .hlt       (hlt)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // ------------------------------
    // Memory helpers
    // ------------------------------
    function automatic word_t read_word(logic from_ref, word_t addr);
        word_t v;
        v = '0;  // Outside the array reads zero
        for (int b = 0; b < 8; b++) begin
            if (addr + 64'(b) < 64'(MEM_BYTES)) begin
                v[8*b +: 8] = from_ref ? ref_mem[addr[15:0] + 16'(b)] : mem[addr[15:0] + 16'(b)];
            end
        end
        return v;
    endfunction

    function automatic void write_word(logic to_ref, word_t addr, word_t v);
        for (int b = 0; b < 8; b++) begin
            if (addr + 64'(b) < 64'(MEM_BYTES)) begin
                if (to_ref) ref_mem[addr[15:0] + 16'(b)] = v[8*b +: 8];  // Little-endian
                else mem[addr[15:0] + 16'(b)] = v[8*b +: 8];
            end
        end
    endfunction

    // Same-cycle answer to a read request
    always_comb mem_rdata = mem_req.read ? read_word(1'b0, mem_req.addr) : '0;

    // ------------------------------
    // Program generation
    // ------------------------------
    function automatic int unsigned rnd(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instr_t encode(logic [4:0] op, int rd, int rs, int rt, logic [11:0] imm);
        return {op, 5'(rd), 5'(rs), 5'(rt), imm};
    endfunction

    function automatic instr_t random_alu();
        return encode(alu_ops[5'(rnd(18))], rnd(32), rnd(32), rnd(32), 12'(rnd(4096)));
    endfunction

    function automatic instr_t random_mem();
        logic [11:0] off;
        off = 12'(DATA_BASE + rnd('h1F9));  // Any alignment inside data area
        if (rnd(2) == 0) return encode(op_store, 0, rnd(32), 0, off);
        return encode(op_load, rnd(32), 0, 0, off);
    endfunction

    function automatic instr_t random_nop();
        return encode(nop_ops[4'(rnd(13))], rnd(32), rnd(32), rnd(32), 12'(rnd(4096)));
    endfunction

    task automatic build_program(int kind);
        prog.delete();
        for (int i = 1; i < 32; i++) begin
            prog.push_back(encode(op_load, i, 0, 0, 12'(DATA_BASE + 8*(i-1))));
        end
        case (kind)
            0: repeat (48) prog.push_back(random_alu());
            1: repeat (40) prog.push_back((rnd(3) == 0) ? random_alu() : random_mem());
            2: begin
                prog.push_back(encode(op_mov_lit, 0, 0, 0, 12'h123));  // r0 stays zero
                prog.push_back(encode(op_add, 0, 1, 2, 12'h0));
                prog.push_back(encode(op_load, 0, 0, 0, 12'(DATA_BASE)));
                prog.push_back(encode(op_mov_lit, 3, 0, 0, 12'h0));
                prog.push_back(encode(op_div, 4, 1, 3, 12'h0));        // Divide by zero
                prog.push_back(encode(op_div, 5, 2, 0, 12'h0));
                prog.push_back(encode(op_mov_lit, 6, 0, 0, 12'd64));
                prog.push_back(encode(op_shftl, 7, 1, 6, 12'h0));      // Shift of exactly 64
                prog.push_back(encode(op_shftr, 8, 1, 6, 12'h0));
                prog.push_back(encode(op_mov_lit, 9, 0, 0, 12'hFFF));  // All ones
                prog.push_back(encode(op_shftri, 10, 9, 0, 12'd100));
                prog.push_back(encode(op_shftri, 11, 2, 0, 12'hFFF)); // Huge amount
                prog.push_back(encode(op_shftli, 12, 1, 0, 12'd64));
                prog.push_back(encode(op_shftr, 13, 1, 9, 12'h0));
                prog.push_back(encode(op_shftri, 14, 2, 0, 12'd63));
                foreach (nop_ops[i]) begin
                    prog.push_back(encode(nop_ops[i], rnd(32), rnd(32), rnd(32),
                                          12'(rnd(4096))));
                end
            end
            default: repeat (60) begin
                case (rnd(4))
                    0, 1: prog.push_back(random_alu());
                    2: prog.push_back(random_mem());
                    default: prog.push_back(random_nop());
                endcase
            end
        endcase
        for (int i = 0; i < 32; i++) begin
            prog.push_back(encode(op_store, 0, i, 0, 12'(DUMP_BASE + 8*i)));
        end
        prog.push_back(encode(op_halt, 0, 0, 0, 12'h0));
    endtask

    task automatic load_memory();
        mem = '{default: 8'h00};
        for (int a = DATA_BASE; a < DATA_BASE + 'h200; a++) mem[16'(a)] = 8'($random(seed));
        foreach (prog[i]) write_word(1'b0, `TINKER_RESET_PC + 64'(4*i), {32'h0, prog[i]});
        ref_mem = mem;  // Model starts from the same image
    endtask

    // ------------------------------
    // Instruction-level model
    // ------------------------------
    task automatic run_model();
        word_t      pc, ir_word, imm, a, b, res;
        logic [4:0] op, rd, rs, rt;
        logic       wr, stop;
        int         steps;
        ref_regs = '{default: '0};
        pc = `TINKER_RESET_PC;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < RUN_LIMIT) begin
            ir_word = read_word(1'b1, pc);
            {op, rd, rs, rt} = ir_word[31:12];
            imm = {{52{ir_word[11]}}, ir_word[11:0]};
            a = ref_regs[rs];
            b = (op inside {op_addi, op_subi, op_shftri, op_shftli, op_mov_lit}) ? imm : ref_regs[rt];
            wr = 1'b1;
            res = '0;
            case (op)
                op_and:            res = a & b;
                op_or:             res = a | b;
                op_xor:            res = a ^ b;
                op_not:            res = ~a;
                op_shftr:          res = (b >= 64) ? '0 : a >> b[5:0];
                op_shftri:         res = (b >= 64) ? {64{a[63]}} : word_t'($signed(a) >>> b[5:0]);
                op_shftl, op_shftli: res = (b >= 64) ? '0 : a << b[5:0];
                op_add, op_addi:   res = a + b;
                op_sub, op_subi:   res = a - b;
                op_mul:            res = a * b;
                op_div:            res = (b == 0) ? '0 : a / b;
                op_mov_rr:         res = a;
                op_mov_lit:        res = imm;
                op_load:           res = read_word(1'b1, a + imm);
                op_store: begin
                    write_word(1'b1, ref_regs[rd] + imm, a);  // Base is rd
                    wr = 1'b0;
                end
                op_halt: begin
                    stop = 1'b1;
                    wr = 1'b0;
                end
                default:           wr = 1'b0;  // Dropped opcode
            endcase
            if (wr && rd != 0) ref_regs[rd] = res;
            pc += 4;
            steps++;
        end
    endtask

    // ------------------------------
    // DUT control and checks
    // ------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    task automatic check_value(string name, string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s: %s expected %h actual %h", name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (test_errors == 0) $display("Test %s: ok", name);
        else begin
            $display("Test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic run_test(string name, int kind);
        int     cyc, last_fetch;
        instr_t last_word;
        logic   done, pend;
        word_t  paddr, pdata;
        test_errors = 0;
        build_program(kind);
        load_memory();
        run_model();
        apply_reset();
        cyc = 0;
        last_fetch = -1;
        last_word = '0;
        done = 1'b0;
        pend = 1'b0;
        while (!done && cyc < RUN_LIMIT) begin
            @(negedge clk);
            cyc++;
            if (hlt) done = 1'b1;
            else begin
                if (mem_req.write) begin
                    pend = 1'b1;  // Lands at the next edge
                    paddr = mem_req.addr;
                    pdata = mem_req.wdata;
                end
                if (mem_req.read && mem_req.addr >= `TINKER_RESET_PC) begin  // Fetch
                    if (last_fetch >= 0) begin
                        check_value(name, "fetch gap",
                                    (last_word[31:27] inside {op_load, op_store}) ? 5 : 4,
                                    word_t'(cyc - last_fetch));
                    end
                    last_fetch = cyc;
                    last_word = mem_rdata[31:0];
                end
                @(posedge clk);
                if (pend) write_word(1'b0, paddr, pdata);
                pend = 1'b0;
            end
        end
        if (!done) begin
            $display("ERROR %s: hlt never rose within %0d cycles", name, RUN_LIMIT);
            test_errors++;
        end else begin
            check_value(name, "halt delay", 2, word_t'(cyc - last_fetch));
            check_value(name, "last opcode", op_halt, word_t'(last_word[31:27]));
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                if (!hlt || mem_req.read || mem_req.write) begin
                    $display("ERROR %s: core left halt or touched memory %0d cycles after hlt",
                             name, i + 1);
                    test_errors++;
                end
            end
            for (int a = DATA_BASE; a < DUMP_BASE + 256; a += 8) begin  // Data and register dump
                check_value(name, $sformatf("word %h", a), read_word(1'b1, a), read_word(1'b0, a));
            end
        end
        finish_test(name);
    endtask

    initial begin
        reset = 1'b1;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
        mem = '{default: 8'h00};
        write_word(1'b0, `TINKER_RESET_PC, {32'h0, encode(op_halt, 0, 0, 0, 12'h0)});
        apply_reset();
        @(negedge clk);  // Still in the first fetch
        check_value("reset_state", "hlt", 0, word_t'(hlt));
        check_value("reset_state", "write", 0, word_t'(mem_req.write));
        check_value("reset_state", "read", 1, word_t'(mem_req.read));
        check_value("reset_state", "addr", `TINKER_RESET_PC, mem_req.addr);
        finish_test("reset_state");
        run_test("alu_random", 0);
        run_test("load_store", 1);
        run_test("corner_rules", 2);
        run_test("mixed_random", 3);
        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+include
source/tinker_pkg.sv
source/core_control.sv
source/instr_fetch.sv
source/reg_file.sv
source/alu.sv
source/mem_access.sv
source/tinker_core.sv
tests/tinker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tinker_tb -o tinker_sim

output=$(./obj_dir/tinker_sim)
echo "$output"

if grep -qx "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1
